//--- zebra_top.f
src/zebra_pkg.sv
src/frame_scan_if.sv
src/edge_filter.sv
src/frame_store.sv
src/binary_readout.sv
src/crossing_detector.sv
src/zebra_top.sv
sim/tb_zebra_top.sv

//--- Makefile
TOP   := tb_zebra_top
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal -f zebra_top.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee sim.log
	@grep -q "^test passed$$" sim.log

clean:
	rm -rf $(BUILD) sim.log

//--- sim/tb_zebra_top.sv
`timescale 1ns/1ps

module tb_zebra_top;

    localparam int CLK_PERIOD  = 40;
    localparam int FRAME_BEATS = zebra_pkg::IMG_W * zebra_pkg::IMG_H;
    localparam int NPIX        = zebra_pkg::FRAME_PIXELS;
    localparam int DETECT_LAT  = 83;
    // Three frames at a worst case of 8 cycles per pixel and a margin of four
    localparam int WATCHDOG_CYCLES = 3 * FRAME_BEATS * 8 * 4;

    logic               clk;
    logic               rst_n;
    logic               x_valid;
    logic               x_ready;
    zebra_pkg::pixel_t  x_data;
    zebra_pkg::kernel_t kernel;
    logic               y_valid;
    logic               y_ready;
    zebra_pkg::pixel_t  y_data;
    logic               capture_trigger;
    logic               capturing;
    logic               frame_ready;
    logic               detection_valid;
    logic               crossing_detected;
    zebra_pkg::count_t  white_pixel_count;
    zebra_pkg::count_t  stripe_count;
    logic               binary_valid;
    logic               binary_ready;
    zebra_pkg::pixel_t  binary_data;

    int   img [zebra_pkg::IMG_H][zebra_pkg::IMG_W];
    int   y_exp [$];
    int   gray_exp [NPIX];
    int   exp_white;
    int   exp_groups;
    int   errors;
    int   checks;
    int   cycle_count;
    int   last_cap_cycle;
    int   y_beats;
    int   bin_beats;
    int   held_data;
    logic hold_pending;
    logic cap_seen;
    logic stall_y;

    zebra_top dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Back-pressure on both output streams
    always @(negedge clk) begin
        y_ready      = stall_y ? ($urandom % 4 != 0) : 1'b1;
        binary_ready = ($urandom % 2) == 0;
    end

    task automatic check_eq(input string name, input int got, input int expected);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d",
                     $time, name, got, expected);
        end
    endtask

    // ========================================
    // Reference model
    // ========================================
    function automatic int window_mag(input int r, input int c);
        int acc;
        acc = 0;
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                acc += img[r - 2 + i][c - 2 + j] * int'(kernel[i][j]);
            end
        end
        if (acc < 0) begin
            acc = -acc;
        end
        return (acc > 255) ? 255 : acc;
    endfunction

    task automatic build_model();
        int m;
        int run;
        int base;
        exp_white  = 0;
        exp_groups = 0;
        for (int r = 2; r < zebra_pkg::IMG_H; r++) begin
            for (int c = 2; c < zebra_pkg::IMG_W; c++) begin
                m = window_mag(r, c);
                y_exp.push_back(m);
                gray_exp[(r - 2) * zebra_pkg::FRAME_W + c - 2] =
                    (m >= zebra_pkg::EDGE_THRESHOLD) ? 255 : 0;
                exp_white += (m >= zebra_pkg::EDGE_THRESHOLD) ? 1 : 0;
            end
        end
        // Row runs of MIN_RUN or more are groups and every pixel of one shows as 128
        for (int fr = 0; fr < zebra_pkg::FRAME_H; fr++) begin
            run  = 0;
            base = fr * zebra_pkg::FRAME_W;
            for (int fc = 0; fc <= zebra_pkg::FRAME_W; fc++) begin
                if (fc < zebra_pkg::FRAME_W && gray_exp[base + fc] != 0) begin
                    run++;
                end else begin
                    if (run >= zebra_pkg::MIN_RUN) begin
                        exp_groups++;
                        for (int k = fc - run; k < fc; k++) begin
                            gray_exp[base + k] = 128;
                        end
                    end
                    run = 0;
                end
            end
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================
    task automatic fill_frame(input int kind);
        for (int r = 0; r < zebra_pkg::IMG_H; r++) begin
            for (int c = 0; c < zebra_pkg::IMG_W; c++) begin
                case (kind)
                    0:       img[r][c] = $urandom % 256;
                    1:       img[r][c] = ((r / 3) % 2 == 1) ? 200 : 20;
                    default: img[r][c] = 100;
                endcase
            end
        end
        // Sparse frame gets one short segment and one isolated dot
        if (kind == 2) begin
            img[3][6] = 140;
            img[3][7] = 140;
            img[3][8] = 140;
            img[6][3] = 140;
        end
    endtask

    task automatic set_random_kernel();
        for (int i = 0; i < 3; i++) begin
            for (int j = 0; j < 3; j++) begin
                kernel[i][j] = zebra_pkg::coef_t'(int'($urandom % 9) - 4);
            end
        end
    endtask

    task automatic send_frame();
        for (int r = 0; r < zebra_pkg::IMG_H; r++) begin
            for (int c = 0; c < zebra_pkg::IMG_W; c++) begin
                @(negedge clk);
                x_valid = 1'b1;
                x_data  = zebra_pkg::pixel_t'(img[r][c]);
                @(posedge clk);
                while (!x_ready) begin
                    @(posedge clk);
                end
            end
        end
        @(negedge clk);
        x_valid = 1'b0;
        while (y_exp.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic pulse_trigger();
        @(negedge clk);
        capture_trigger = 1'b1;
        @(negedge clk);
        capture_trigger = 1'b0;
    endtask

    task automatic wait_readout();
        do @(posedge clk); while (!detection_valid);
        do @(posedge clk); while (bin_beats < NPIX);
        repeat (10) @(posedge clk);
        check_eq("binary beat count", bin_beats, NPIX);
    endtask

    // ========================================
    // Output monitor
    // ========================================
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count++;
            if (capturing) begin
                if (!cap_seen) begin
                    check_eq("y_valid at capture start", y_valid, 1);
                    check_eq("window index at capture start", y_beats % NPIX, 0);
                end
                last_cap_cycle = cycle_count;
            end
            cap_seen = capturing;
            // Store hands over to the detector on the cycle after its last write
            if (frame_ready) begin
                check_eq("frame_ready delay", cycle_count - last_cap_cycle, 1);
            end
            if (hold_pending) begin
                check_eq("y_valid", y_valid, 1);
                check_eq("y_data", y_data, held_data);
            end
            hold_pending = y_valid && !y_ready;
            held_data    = y_data;
            if (y_valid && y_ready) begin
                y_beats++;
                if (y_exp.size() == 0) begin
                    errors++;
                    $display("Unexpected y beat at %0t ns, no model value left", $time);
                end else begin
                    check_eq("y_data", y_data, y_exp.pop_front());
                end
            end
            if (detection_valid) begin
                check_eq("detection latency", cycle_count - last_cap_cycle, DETECT_LAT);
                check_eq("white_pixel_count", white_pixel_count, exp_white);
                check_eq("stripe_count", stripe_count, exp_groups);
                check_eq("crossing_detected", crossing_detected,
                         exp_groups >= zebra_pkg::MIN_GROUPS);
                bin_beats = 0;
            end
            if (binary_valid && binary_ready) begin
                if (bin_beats >= NPIX) begin
                    errors++;
                    $display("Binary stream sent more than %0d beats at %0t ns", NPIX, $time);
                end else begin
                    check_eq("binary_data", binary_data, gray_exp[bin_beats]);
                end
                bin_beats++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        errors++;
        $display("Timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hf30f));
        clk             = 1'b0;
        rst_n           = 1'b0;
        x_valid         = 1'b0;
        x_data          = '0;
        y_ready         = 1'b1;
        binary_ready    = 1'b1;
        capture_trigger = 1'b0;
        stall_y         = 1'b0;
        hold_pending    = 1'b0;
        cap_seen        = 1'b0;
        set_random_kernel();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_eq("y_valid", y_valid, 0);
        check_eq("binary_valid", binary_valid, 0);
        check_eq("capturing", capturing, 0);
        check_eq("frame_ready", frame_ready, 0);
        check_eq("detection_valid", detection_valid, 0);
        check_eq("crossing_detected", crossing_detected, 0);
        check_eq("white_pixel_count", white_pixel_count, 0);
        check_eq("stripe_count", stripe_count, 0);
        check_eq("x_ready", x_ready, 1);

        // Random frame under y stalls without capture
        stall_y = 1'b1;
        fill_frame(0);
        build_model();
        send_frame();
        stall_y = 1'b0;

        // Vertical Sobel turns horizontal bars into full-row edges
        kernel = '{'{-1, -2, -1}, '{0, 0, 0}, '{1, 2, 1}};
        fill_frame(1);
        build_model();
        pulse_trigger();
        send_frame();
        wait_readout();

        fill_frame(2);
        build_model();
        pulse_trigger();
        send_frame();
        wait_readout();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src/zebra_top.sv
`timescale 1ns/1ps

module zebra_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               x_valid,
    output logic               x_ready,
    input  zebra_pkg::pixel_t  x_data,
    input  zebra_pkg::kernel_t kernel,
    output logic               y_valid,
    input  logic               y_ready,
    output zebra_pkg::pixel_t  y_data,
    input  logic               capture_trigger,
    output logic               capturing,
    output logic               frame_ready,
    output logic               detection_valid,
    output logic               crossing_detected,
    output zebra_pkg::count_t  white_pixel_count,
    output zebra_pkg::count_t  stripe_count,
    output logic               binary_valid,
    input  logic               binary_ready,
    output zebra_pkg::pixel_t  binary_data
);

    logic             edge_valid;
    logic             edge_bit;
    logic             edge_first;
    zebra_pkg::addr_t disp_addr;
    zebra_pkg::cell_t disp_data;

    frame_scan_if u_scan_if ();

    edge_filter u_edge_filter (
        .clk        (clk),
        .rst_n      (rst_n),
        .x_valid    (x_valid),
        .x_ready    (x_ready),
        .x_data     (x_data),
        .kernel     (kernel),
        .y_valid    (y_valid),
        .y_ready    (y_ready),
        .y_data     (y_data),
        .edge_valid (edge_valid),
        .edge_bit   (edge_bit),
        .edge_first (edge_first)
    );

    frame_store u_frame_store (
        .clk             (clk),
        .rst_n           (rst_n),
        .capture_trigger (capture_trigger),
        .edge_valid      (edge_valid),
        .edge_bit        (edge_bit),
        .edge_first      (edge_first),
        .disp_addr       (disp_addr),
        .scan            (u_scan_if.store),
        .capturing       (capturing),
        .frame_ready     (frame_ready),
        .disp_data       (disp_data)
    );

    crossing_detector u_crossing_detector (
        .clk               (clk),
        .rst_n             (rst_n),
        .frame_ready       (frame_ready),
        .scan              (u_scan_if.detector),
        .detection_valid   (detection_valid),
        .crossing_detected (crossing_detected),
        .white_pixel_count (white_pixel_count),
        .stripe_count      (stripe_count)
    );

    binary_readout u_binary_readout (
        .clk             (clk),
        .rst_n           (rst_n),
        .detection_valid (detection_valid),
        .binary_ready    (binary_ready),
        .disp_data       (disp_data),
        .disp_addr       (disp_addr),
        .binary_valid    (binary_valid),
        .binary_data     (binary_data)
    );

endmodule

//--- src/crossing_detector.sv
`timescale 1ns/1ps

module crossing_detector (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              frame_ready,
    frame_scan_if.detector    scan,
    output logic              detection_valid,
    output logic              crossing_detected,
    output zebra_pkg::count_t white_pixel_count,
    output zebra_pkg::count_t stripe_count
);

    typedef logic [$clog2(zebra_pkg::FRAME_W)-1:0]   col_t;
    typedef logic [$clog2(zebra_pkg::FRAME_W+1)-1:0] len_t;
    typedef logic [$clog2(zebra_pkg::MIN_RUN+1)-1:0] pend_t;

    logic              scanning;
    zebra_pkg::addr_t  rd_addr;
    logic              proc_valid;
    logic              proc_last;
    zebra_pkg::addr_t  proc_addr;
    col_t              col;
    len_t              run_len;
    len_t              base_len;
    len_t              len_now;
    zebra_pkg::addr_t  run_start;
    zebra_pkg::addr_t  start_now;
    logic              is_white;
    logic              row_end;
    logic              reach;
    logic              extend;
    logic              group_end;
    zebra_pkg::count_t groups_next;
    pend_t             pending;
    zebra_pkg::addr_t  mark_ptr;

    assign scan.scan_addr = rd_addr;
    assign scan.mark_we   = pending != '0;
    assign scan.mark_addr = mark_ptr;

    // ========================================
    // Address sweep, one read per cycle
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scanning   <= 1'b0;
            rd_addr    <= '0;
            proc_valid <= 1'b0;
            proc_last  <= 1'b0;
            proc_addr  <= '0;
        end else begin
            proc_valid <= scanning;
            proc_last  <= scanning &&
                          rd_addr == zebra_pkg::addr_t'(zebra_pkg::FRAME_PIXELS - 1);
            proc_addr  <= rd_addr;
            if (frame_ready) begin
                scanning <= 1'b1;
                rd_addr  <= '0;
            end else if (scanning) begin
                if (rd_addr == zebra_pkg::addr_t'(zebra_pkg::FRAME_PIXELS - 1)) begin
                    scanning <= 1'b0;
                    rd_addr  <= '0;
                end else begin
                    rd_addr <= rd_addr + 1'b1;
                end
            end
        end
    end

    // Runs never cross a row boundary
    assign is_white  = scan.scan_data != zebra_pkg::CELL_BLACK;
    assign row_end   = col == col_t'(zebra_pkg::FRAME_W - 1);
    assign base_len  = (col == '0) ? '0 : run_len;
    assign len_now   = is_white ? base_len + 1'b1 : '0;
    assign start_now = (base_len == '0) ? proc_addr : run_start;
    assign reach     = proc_valid && is_white && len_now == len_t'(zebra_pkg::MIN_RUN);
    assign extend    = proc_valid && is_white && len_now > len_t'(zebra_pkg::MIN_RUN);
    assign group_end = proc_valid &&
                       (is_white ? (row_end && len_now >= len_t'(zebra_pkg::MIN_RUN))
                                 : (base_len >= len_t'(zebra_pkg::MIN_RUN)));
    assign groups_next = stripe_count + zebra_pkg::count_t'(group_end);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col               <= '0;
            run_len           <= '0;
            run_start         <= '0;
            white_pixel_count <= '0;
            stripe_count      <= '0;
            detection_valid   <= 1'b0;
            crossing_detected <= 1'b0;
        end else begin
            detection_valid <= proc_valid && proc_last;
            if (frame_ready) begin
                col               <= '0;
                run_len           <= '0;
                white_pixel_count <= '0;
                stripe_count      <= '0;
                crossing_detected <= 1'b0;
            end else if (proc_valid) begin
                col               <= row_end ? '0 : col + 1'b1;
                run_len           <= len_now;
                run_start         <= start_now;
                white_pixel_count <= white_pixel_count + zebra_pkg::count_t'(is_white);
                stripe_count      <= groups_next;
                if (proc_last) begin
                    crossing_detected <= groups_next >= zebra_pkg::count_t'(zebra_pkg::MIN_GROUPS);
                end
            end
        end
    end

    // Pending marks form a contiguous range starting at mark_ptr.
    // Reaching MIN_RUN replays from the run start, later pixels extend the range
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= '0;
            mark_ptr <= '0;
        end else if (reach) begin
            pending  <= pend_t'(zebra_pkg::MIN_RUN);
            mark_ptr <= start_now;
        end else begin
            pending <= pending - pend_t'(pending != '0) + pend_t'(extend);
            if (pending != '0) begin
                mark_ptr <= mark_ptr + 1'b1;
            end
        end
    end

endmodule

//--- src/binary_readout.sv
`timescale 1ns/1ps

module binary_readout (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              detection_valid,
    input  logic              binary_ready,
    input  zebra_pkg::cell_t  disp_data,
    output zebra_pkg::addr_t  disp_addr,
    output logic              binary_valid,
    output zebra_pkg::pixel_t binary_data
);

    zebra_pkg::addr_t  rd_ptr;
    logic              fetch_valid;
    logic              advance;
    logic              take;
    logic              last;
    zebra_pkg::pixel_t gray;

    assign advance = binary_ready || !binary_valid;
    assign take    = fetch_valid && advance;
    assign last    = rd_ptr == zebra_pkg::addr_t'(zebra_pkg::FRAME_PIXELS - 1);

    // disp_data always belongs to rd_ptr, so a stall simply rereads it
    always_comb begin
        if (!take) begin
            disp_addr = rd_ptr;
        end else if (last) begin
            disp_addr = '0;
        end else begin
            disp_addr = rd_ptr + 1'b1;
        end
    end

    always_comb begin
        case (disp_data)
            zebra_pkg::CELL_WHITE:   gray = 8'd255;
            zebra_pkg::CELL_VISITED: gray = 8'd128;
            default:                 gray = 8'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr       <= '0;
            fetch_valid  <= 1'b0;
            binary_valid <= 1'b0;
        end else begin
            rd_ptr <= disp_addr;
            if (detection_valid && !fetch_valid) begin
                fetch_valid <= 1'b1;
            end else if (take && last) begin
                fetch_valid <= 1'b0;
            end
            if (advance) begin
                binary_valid <= fetch_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            binary_data <= gray;
        end
    end

endmodule

//--- src/frame_store.sv
`timescale 1ns/1ps

module frame_store (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             capture_trigger,
    input  logic             edge_valid,
    input  logic             edge_bit,
    input  logic             edge_first,
    input  zebra_pkg::addr_t disp_addr,
    frame_scan_if.store      scan,
    output logic             capturing,
    output logic             frame_ready,
    output zebra_pkg::cell_t disp_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARMED,
        ST_CAPTURE
    } state_t;

    state_t           state;
    zebra_pkg::addr_t wr_addr;
    zebra_pkg::cell_t mem [zebra_pkg::FRAME_PIXELS];
    logic             wr_en;
    logic             wr_last;

    // Armed store waits for the first window of a frame
    assign wr_en = edge_valid &&
                   (state == ST_CAPTURE || (state == ST_ARMED && edge_first));
    assign wr_last = wr_en &&
                     wr_addr == zebra_pkg::addr_t'(zebra_pkg::FRAME_PIXELS - 1);

    // High from the first written beat through the last one
    assign capturing = wr_en || state == ST_CAPTURE;

    // ========================================
    // Arm and capture control
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            wr_addr     <= '0;
            frame_ready <= 1'b0;
        end else begin
            frame_ready <= wr_last;
            if (wr_en) begin
                wr_addr <= wr_last ? '0 : wr_addr + 1'b1;
            end
            case (state)
                ST_IDLE: begin
                    if (capture_trigger) begin
                        state <= ST_ARMED;
                    end
                end
                ST_ARMED: begin
                    if (wr_en) begin
                        state <= ST_CAPTURE;
                    end
                end
                ST_CAPTURE: begin
                    if (wr_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Capture has priority; marks only happen between captures
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= edge_bit ? zebra_pkg::CELL_WHITE : zebra_pkg::CELL_BLACK;
        end else if (scan.mark_we) begin
            mem[scan.mark_addr] <= zebra_pkg::CELL_VISITED;
        end
        scan.scan_data <= mem[scan.scan_addr];
        disp_data      <= mem[disp_addr];
    end

endmodule

//--- src/edge_filter.sv
`timescale 1ns/1ps

module edge_filter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               x_valid,
    output logic               x_ready,
    input  zebra_pkg::pixel_t  x_data,
    input  zebra_pkg::kernel_t kernel,
    output logic               y_valid,
    input  logic               y_ready,
    output zebra_pkg::pixel_t  y_data,
    output logic               edge_valid,
    output logic               edge_bit,
    output logic               edge_first
);

    typedef logic [$clog2(zebra_pkg::IMG_W)-1:0] col_t;
    typedef logic [$clog2(zebra_pkg::IMG_H)-1:0] row_t;

    zebra_pkg::pixel_t line0 [zebra_pkg::IMG_W];
    zebra_pkg::pixel_t line1 [zebra_pkg::IMG_W];
    zebra_pkg::pixel_t win   [3][3];
    col_t              col;
    row_t              row;
    logic              win_valid;
    logic              win_first;
    logic              advance;
    logic              accept;
    logic signed [19:0] acc;
    logic [19:0]       abs_acc;
    zebra_pkg::pixel_t mag;

    // Window and output move together, so one condition gates both stages
    assign advance = y_ready || !y_valid;
    assign x_ready = advance;
    assign accept  = x_valid && advance;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (accept) begin
            if (col == col_t'(zebra_pkg::IMG_W - 1)) begin
                col <= '0;
                row <= (row == row_t'(zebra_pkg::IMG_H - 1)) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // line0 holds the previous image row, line1 the one before it
    always_ff @(posedge clk) begin
        if (accept) begin
            line1[col] <= line0[col];
            line0[col] <= x_data;
            for (int r = 0; r < 3; r++) begin
                win[r][0] <= win[r][1];
                win[r][1] <= win[r][2];
            end
            win[0][2] <= line1[col];
            win[1][2] <= line0[col];
            win[2][2] <= x_data;
        end
    end

    // ========================================
    // Signed sum of products and clamp
    // ========================================
    always_comb begin
        acc = '0;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                acc = acc + $signed({1'b0, win[r][c]}) * kernel[r][c];
            end
        end
    end

    assign abs_acc = acc[19] ? -acc : acc;
    assign mag     = (abs_acc > 20'd255) ? 8'hff : abs_acc[7:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid  <= 1'b0;
            win_first  <= 1'b0;
            y_valid    <= 1'b0;
            edge_valid <= 1'b0;
            edge_first <= 1'b0;
        end else begin
            // Edge strobes last a single cycle even when y stalls
            edge_valid <= 1'b0;
            edge_first <= 1'b0;
            if (advance) begin
                win_valid  <= accept && row >= 2 && col >= 2;
                win_first  <= accept && row == 2 && col == 2;
                y_valid    <= win_valid;
                edge_valid <= win_valid;
                edge_first <= win_first;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && win_valid) begin
            y_data   <= mag;
            edge_bit <= mag >= zebra_pkg::EDGE_THRESHOLD;
        end
    end

endmodule

//--- src/frame_scan_if.sv
`timescale 1ns/1ps

// Detector side of the frame memory: one scan read port plus a mark write port
interface frame_scan_if;

    zebra_pkg::addr_t scan_addr;
    zebra_pkg::cell_t scan_data;
    logic             mark_we;
    zebra_pkg::addr_t mark_addr;

    modport detector (
        output scan_addr,
        output mark_we,
        output mark_addr,
        input  scan_data
    );

    modport store (
        input  scan_addr,
        input  mark_we,
        input  mark_addr,
        output scan_data
    );

endinterface

//--- src/zebra_pkg.sv
package zebra_pkg;

    // ========================================
    // Image geometry
    // ========================================
    localparam int IMG_W = 12;
    localparam int IMG_H = 10;

    // Interior of the input frame, one pixel lost on every border
    localparam int FRAME_W      = IMG_W - 2;
    localparam int FRAME_H      = IMG_H - 2;
    localparam int FRAME_PIXELS = FRAME_W * FRAME_H;

    localparam int PIX_W = 8;

    // ========================================
    // Detection thresholds
    // ========================================
    localparam int EDGE_THRESHOLD = 64;
    localparam int MIN_RUN        = 3;
    localparam int MIN_GROUPS     = 4;

    typedef logic [PIX_W-1:0] pixel_t;
    typedef logic signed [7:0] coef_t;

    // Indexed [row][col], row 0 is the oldest image line
    typedef coef_t kernel_t [0:2][0:2];

    // Row-major over FRAME_W
    typedef logic [$clog2(FRAME_PIXELS)-1:0] addr_t;

    typedef enum logic [1:0] {
        CELL_BLACK   = 2'b00,
        CELL_WHITE   = 2'b01,
        CELL_VISITED = 2'b10
    } cell_t;

    typedef logic [7:0] count_t;

endpackage
